// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_cdbus_tx
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/baud_rate.sv ====
// ************************************************
// bit clock, inc every div + 1 clocks, cap at mid bit
// sync restarts the bit, sel picks div_hs over div_ls
// ************************************************
module baud_rate (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            sync,
    input  logic            sel,
    input  cdbus_pkg::div_t div_ls,
    input  cdbus_pkg::div_t div_hs,
    output logic            inc,
    output logic            cap
);
    import cdbus_pkg::*;

    div_t div;
    div_t cnt;

    assign div = sel ? div_hs : div_ls;

    // >= covers a switch to a shorter divisor mid-count
    assign inc = cnt >= div;
    assign cap = cnt == (div >> 1);   // middle of the bit

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt <= '0;
        end else if (sync || inc) begin
            cnt <= '0;                // next bit starts here
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== hw/cdbus_config.svh ====
// ************************************************
// build constants for the transmit path
// frame depth counts payload only, the CRC is extra
// ************************************************
`ifndef CDBUS_CONFIG_SVH
`define CDBUS_CONFIG_SVH

// bit clock divisor, a bit lasts div + 1 clocks
`define CDBUS_DIV_W 16

`define CDBUS_LEN_W 10           // idle wait count, in bit times
`define CDBUS_FRAME_MAX 16       // payload bytes per frame

// CRC-16/MODBUS, reflected form, no final xor
`define CDBUS_CRC_POLY 16'hA001
`define CDBUS_CRC_SEED 16'hFFFF

`endif

// ==== hw/cdbus_pkg.sv ====
// ************************************************
// shared bus types, widths come from cdbus_config.svh
// ************************************************
`include "cdbus_config.svh"

package cdbus_pkg;

    typedef logic [7:0] byte_t;                     // one bus character payload

    // bit clock divisor
    typedef logic [`CDBUS_DIV_W-1:0] div_t;

    typedef logic [`CDBUS_LEN_W-1:0] len_t;         // idle count in bit times

    // CRC, low byte goes on the line first
    typedef logic [15:0] crc_t;

endpackage

// ==== hw/cdbus_tx_top.sv ====
// ************************************************
// transmit node, config inputs held steady while busy
// send_break must drop once break_done pulses
// ************************************************
module cdbus_tx_top (
    input  logic             clk,
    input  logic             reset_n,
    input  cdbus_pkg::byte_t in_data,
    input  logic             in_valid,
    input  logic             in_last,
    output logic             in_ready,
    output logic             frame_done,
    input  cdbus_pkg::div_t  div_ls,
    input  cdbus_pkg::div_t  div_hs,
    input  cdbus_pkg::len_t  tx_permit_len,
    input  logic [1:0]       tx_pre_len,
    input  logic             arbitration,
    input  logic             abort,
    input  logic             send_break,
    input  logic             rx,
    input  logic             bus_idle,
    output logic             tx,
    output logic             tx_en,
    output logic             cd,
    output logic             err,
    output logic             break_done
);
    import cdbus_pkg::*;

    byte_t buf_data;
    logic  has_data;
    logic  is_crc_byte;
    logic  is_last_byte;
    logic  ack_data;
    crc_t  crc_data;

    tx_frame_buf u_tx_frame_buf (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_ready     (in_ready),
        .data         (buf_data),
        .has_data     (has_data),
        .is_crc_byte  (is_crc_byte),
        .is_last_byte (is_last_byte),
        .ack_data     (ack_data),
        .crc_data     (crc_data),
        .cd           (cd),
        .err          (err),
        .frame_done   (frame_done)
    );

    tx_ser u_tx_ser (
        .clk           (clk),
        .reset_n       (reset_n),
        .data          (buf_data),
        .has_data      (has_data),
        .ack_data      (ack_data),
        .is_crc_byte   (is_crc_byte),
        .is_last_byte  (is_last_byte),
        .crc_data      (crc_data),
        .has_break     (send_break),
        .ack_break     (break_done),
        .bus_idle      (bus_idle),
        .div_ls        (div_ls),
        .div_hs        (div_hs),
        .tx_permit_len (tx_permit_len),
        .tx_pre_len    (tx_pre_len),
        .arbitration   (arbitration),
        .abort         (abort),
        .cd            (cd),
        .err           (err),
        .rx            (rx),
        .tx            (tx),
        .tx_en         (tx_en)
    );

endmodule

// ==== hw/serial_crc.sv ====
// ************************************************
// bit-serial CRC, LSB first, one bit per data_clk
// ************************************************
`include "cdbus_config.svh"

module serial_crc (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            clean,
    input  logic            data_clk,
    input  logic            data_in,
    output cdbus_pkg::crc_t crc_out
);
    import cdbus_pkg::*;

    crc_t crc_next;
    logic feedback;

    // reflected shift, the poly folds in at the top
    assign feedback = crc_out[0] ^ data_in;
    assign crc_next = (crc_out >> 1) ^ (feedback ? crc_t'(`CDBUS_CRC_POLY) : crc_t'(0));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc_out <= crc_t'(`CDBUS_CRC_SEED);
        end else if (clean) begin
            crc_out <= crc_t'(`CDBUS_CRC_SEED);   // held between frames
        end else if (data_clk) begin
            crc_out <= crc_next;
        end
    end

endmodule

// ==== hw/tx_frame_buf.sv ====
// ************************************************
// one-frame store, payload then CRC low and high
// a frame is cut at CDBUS_FRAME_MAX bytes
// ************************************************
`include "cdbus_config.svh"

module tx_frame_buf (
    input  logic             clk,
    input  logic             reset_n,
    input  cdbus_pkg::byte_t in_data,
    input  logic             in_valid,
    input  logic             in_last,
    output logic             in_ready,
    output cdbus_pkg::byte_t data,
    output logic             has_data,
    output logic             is_crc_byte,
    output logic             is_last_byte,
    input  logic             ack_data,
    input  cdbus_pkg::crc_t  crc_data,
    input  logic             cd,
    input  logic             err,
    output logic             frame_done
);
    import cdbus_pkg::*;

    localparam int ADDR_W = $clog2(`CDBUS_FRAME_MAX);
    localparam int IDX_W  = $clog2(`CDBUS_FRAME_MAX + 2);   // room for both CRC bytes

    byte_t            mem [`CDBUS_FRAME_MAX];
    logic [IDX_W-1:0] wr_cnt;       // payload length
    logic [IDX_W-1:0] rd_idx;
    logic             sending;
    logic             accept;
    crc_t             crc_hold;

    assign in_ready = !sending;
    assign accept   = in_valid && in_ready;
    assign has_data = sending;

    assign is_crc_byte  = rd_idx >= wr_cnt;
    assign is_last_byte = rd_idx == wr_cnt + 1'b1;   // CRC high byte

    always_comb begin
        if (!is_crc_byte)
            data = mem[rd_idx[ADDR_W-1:0]];
        else if (rd_idx == wr_cnt)
            data = crc_hold[7:0];
        else
            data = crc_hold[15:8];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sending    <= 1'b0;
            wr_cnt     <= '0;
            rd_idx     <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (!sending) begin
                if (accept) begin
                    wr_cnt <= wr_cnt + 1'b1;
                    if (in_last || wr_cnt == IDX_W'(`CDBUS_FRAME_MAX - 1)) begin
                        sending <= 1'b1;
                        rd_idx  <= '0;
                    end
                end
            end else if (cd || err) begin
                rd_idx <= '0;                // lost the bus, start over
            end else if (ack_data) begin
                if (is_last_byte) begin
                    sending    <= 1'b0;
                    wr_cnt     <= '0;
                    frame_done <= 1'b1;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            mem[wr_cnt[ADDR_W-1:0]] <= in_data;
        // CRC is final once the last payload byte is out
        if (sending && ack_data && rd_idx == wr_cnt - 1'b1)
            crc_hold <= crc_data;
    end

endmodule

// ==== hw/tx_ser.sv ====
// ************************************************
// bus serializer, 10-bit characters, LSB first
// arbitration covers the first character only
// has_break must drop once ack_break is seen
// ************************************************
module tx_ser (
    input  logic               clk,
    input  logic               reset_n,
    input  cdbus_pkg::byte_t   data,
    input  logic               has_data,
    output logic               ack_data,
    input  logic               is_crc_byte,
    input  logic               is_last_byte,
    output cdbus_pkg::crc_t    crc_data,
    input  logic               has_break,
    output logic               ack_break,
    input  logic               bus_idle,
    input  cdbus_pkg::div_t    div_ls,
    input  cdbus_pkg::div_t    div_hs,
    input  cdbus_pkg::len_t    tx_permit_len,
    input  logic [1:0]         tx_pre_len,
    input  logic               arbitration,
    input  logic               abort,
    output logic               cd,
    output logic               err,
    input  logic               rx,
    output logic               tx,
    output logic               tx_en
);
    import cdbus_pkg::*;

    localparam logic [2:0] S_WAIT = 3'b001;
    localparam logic [2:0] S_PRE  = 3'b010;
    localparam logic [2:0] S_DATA = 3'b100;

    logic [2:0] state;
    len_t       wait_cnt;
    logic       tx_permit;
    logic [1:0] pre_cnt;
    logic [3:0] bit_cnt;        // 0 start, 1..8 data, 9 stop
    logic       is_break;
    logic       arb_field;
    logic       baud_sel;
    logic       baud_sync;
    logic       bit_inc;
    logic       bit_cap;
    logic       start;
    logic       pre_done;
    logic       collide;
    logic       crc_en;
    logic       next_bit;
    logic [9:0] tx_char;

    assign tx_char  = is_break ? 10'd0 : {1'b1, data, 1'b0};
    assign next_bit = tx_char[bit_cnt + 4'd1];

    assign start    = state == S_WAIT && tx_permit && (has_data || has_break);
    assign pre_done = state == S_PRE && bit_inc && pre_cnt == tx_pre_len - 2'd1;

    // bit edges follow the bus going idle and the frame start
    assign baud_sync = (state == S_WAIT && (!bus_idle || start)) || pre_done;

    // readback differs from what we drive at mid bit
    assign collide = state == S_DATA && arb_field && bit_cap && tx != rx;

    assign crc_en = state == S_DATA && bit_inc && !is_break && !is_crc_byte &&
                    bit_cnt >= 4'd1 && bit_cnt <= 4'd8;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wait_cnt  <= '0;
            tx_permit <= 1'b0;
        end else if (state != S_WAIT || !bus_idle) begin
            wait_cnt  <= '0;
            tx_permit <= 1'b0;
        end else if (bit_inc && !tx_permit) begin
            wait_cnt <= wait_cnt + 1'b1;
            if (wait_cnt >= tx_permit_len)   // tx_permit_len + 1 idle bits
                tx_permit <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= S_WAIT;
            pre_cnt   <= '0;
            bit_cnt   <= '0;
            is_break  <= 1'b0;
            arb_field <= 1'b0;
            baud_sel  <= 1'b0;
            ack_data  <= 1'b0;
            ack_break <= 1'b0;
            cd        <= 1'b0;
            err       <= 1'b0;
            tx        <= 1'b1;
            tx_en     <= 1'b0;
        end else begin
            ack_data  <= 1'b0;
            ack_break <= 1'b0;
            cd        <= 1'b0;
            err       <= 1'b0;

            case (state)
                S_WAIT: begin
                    baud_sel <= 1'b0;
                    pre_cnt  <= '0;
                    bit_cnt  <= '0;
                    if (start) begin
                        is_break  <= has_break;
                        arb_field <= arbitration && !has_break;
                        tx_en     <= 1'b1;
                        // no preamble under arbitration
                        if (arbitration || tx_pre_len == 2'd0) begin
                            state <= S_DATA;
                            tx    <= 1'b0;   // start bit
                        end else begin
                            state <= S_PRE;
                        end
                    end
                end

                S_PRE: begin
                    if (bit_inc)
                        pre_cnt <= pre_cnt + 1'b1;
                    if (pre_done) begin
                        state <= S_DATA;
                        tx    <= 1'b0;
                    end
                end

                S_DATA: begin
                    if (collide) begin
                        cd    <= tx && !rx;   // recessive one overridden
                        err   <= !tx && rx;
                        state <= S_WAIT;
                        tx    <= 1'b1;
                        tx_en <= 1'b0;
                    end else if (bit_inc) begin
                        if (bit_cnt != 4'd9) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= next_bit;
                            // release the line for ones while arbitrating
                            tx_en   <= !(arb_field && next_bit);
                        end else if (is_break) begin
                            ack_break <= 1'b1;
                            state     <= S_WAIT;
                            tx        <= 1'b1;
                            tx_en     <= 1'b0;
                        end else begin
                            ack_data  <= 1'b1;
                            baud_sel  <= 1'b1;   // high rate from byte 1 on
                            arb_field <= 1'b0;
                            bit_cnt   <= '0;
                            if (is_last_byte) begin
                                state <= S_WAIT;
                                tx    <= 1'b1;
                                tx_en <= 1'b0;
                            end else begin
                                tx    <= 1'b0;   // next start bit
                                tx_en <= 1'b1;
                            end
                        end
                    end
                end

                default: begin
                    state <= S_WAIT;
                    tx    <= 1'b1;
                    tx_en <= 1'b0;
                end
            endcase

            if (abort) begin
                state <= S_WAIT;
                cd    <= 1'b0;
                err   <= 1'b0;
                tx    <= 1'b1;
                tx_en <= 1'b0;
            end
        end
    end

    baud_rate u_baud_rate (
        .clk     (clk),
        .reset_n (reset_n),
        .sync    (baud_sync),
        .sel     (baud_sel),
        .div_ls  (div_ls),
        .div_hs  (div_hs),
        .inc     (bit_inc),
        .cap     (bit_cap)
    );

    serial_crc u_serial_crc (
        .clk      (clk),
        .reset_n  (reset_n),
        .clean    (state == S_WAIT),
        .data_clk (crc_en),
        .data_in  (tx),
        .crc_out  (crc_data)
    );

endmodule

// ==== tb.f ====
+incdir+hw
hw/cdbus_pkg.sv
hw/baud_rate.sv
hw/serial_crc.sv
hw/tx_ser.sv
hw/tx_frame_buf.sv
hw/cdbus_tx_top.sv
test/tb_clock_gen.sv
test/tb_cdbus_tx.sv

// ==== test/tb_cdbus_tx.sv ====
// **************************************************
// transmit node testbench with the line decoded at mid bit
// rx is a wired-and of tx and a forced low
// **************************************************
module tb_cdbus_tx;
    import cdbus_pkg::*;

    localparam int N_TESTS    = 5;
    localparam int WAIT_LIMIT = 5000;   // negedges per wait

    typedef struct packed {
        int len;
        int div_ls;
        int div_hs;
        int arb;
        int pre;
        int n_col;
        int brk;
    } test_t;

    logic  clk;
    logic  reset_n;
    byte_t in_data;
    logic  in_valid;
    logic  in_last;
    logic  in_ready;
    logic  frame_done;
    div_t  div_ls;
    div_t  div_hs;
    len_t  tx_permit_len;
    logic [1:0] tx_pre_len;
    logic  arbitration;
    logic  abort;
    logic  send_break;
    logic  bus_idle;
    logic  tx;
    logic  tx_en;
    logic  cd;
    logic  err;
    logic  break_done;
    logic  pull_low;                    // another node driving a zero
    wire   rx = tx & ~pull_low;

    test_t       tests [N_TESTS];
    logic [7:0]  frame_q [$];
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          cd_cnt;
    int          err_cnt;

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(5)) u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    cdbus_tx_top DUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .in_data       (in_data),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .in_ready      (in_ready),
        .frame_done    (frame_done),
        .div_ls        (div_ls),
        .div_hs        (div_hs),
        .tx_permit_len (tx_permit_len),
        .tx_pre_len    (tx_pre_len),
        .arbitration   (arbitration),
        .abort         (abort),
        .send_break    (send_break),
        .rx            (rx),
        .bus_idle      (bus_idle),
        .tx            (tx),
        .tx_en         (tx_en),
        .cd            (cd),
        .err           (err),
        .break_done    (break_done)
    );

    always @(negedge clk) begin
        if (cd === 1'b1)
            cd_cnt <= cd_cnt + 1;
        if (err === 1'b1)
            err_cnt <= err_cnt + 1;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    // taps x^32 + x^22 + x^2 + x + 1 when shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic next_rand_byte(output logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++) begin
            b[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // CRC-16/MODBUS applied one byte at a time
    function automatic logic [15:0] crc_add_byte(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        int i;
        c = crc ^ {8'h00, b};
        for (i = 0; i < 8; i++)
            c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
        return c;
    endfunction

    task automatic push_byte(input logic [7:0] b, input logic last);
        int n;
        @(posedge clk);
        in_data  <= b;
        in_valid <= 1'b1;
        in_last  <= last;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timed_out("in_ready");
        end while (in_ready !== 1'b1);   // byte moves on the next edge
    endtask

    task automatic watch_quiet_line(input int cycles);
        int bad;
        int i;
        bad = 0;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (tx !== 1'b1 || tx_en !== 1'b0)
                bad++;
        end
        check("tx activity while bus busy", bad, 0);
    endtask

    // one 10-bit character with every clock compared to its bit slot
    task automatic receive_char(input int div, input bit arb_first, input logic [7:0] want,
                                input int idx, input int pre_clocks);
        logic [9:0] bits;
        logic [9:0] sent;
        int bit_len;
        int off_grid;
        int bad_en;
        int pre_seen;
        int n;
        int i;
        int b;
        bit_len  = div + 1;
        sent     = {1'b1, want, 1'b0};
        bits     = '0;
        off_grid = 0;
        bad_en   = 0;
        pre_seen = 0;
        n        = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timed_out("a start bit");
            if (tx === 1'b1 && tx_en === 1'b1)
                pre_seen++;                 // preamble holds the line high
        end while (tx !== 1'b0);
        for (i = 0; i < 10 * bit_len; i++) begin
            if (i > 0)
                @(negedge clk);
            b = i / bit_len;
            if (i % bit_len == bit_len / 2)
                bits[b] = tx;               // mid bit
            if (tx !== sent[b])
                off_grid++;
            if (tx_en !== (arb_first ? !sent[b] : 1'b1))
                bad_en++;                   // ones are released while arbitrating
        end
        check("preamble clocks", pre_seen, pre_clocks);
        check($sformatf("tx byte %0d", idx), 32'(bits[8:1]), 32'(want));
        check("tx stop bit", 32'(bits[9]), 32'd1);
        check("tx edges off the bit grid", off_grid, 0);
        check("tx_en", bad_en, 0);
    endtask

    task automatic send_break_char(input int div);
        int n;
        int low;
        @(posedge clk);
        send_break <= 1'b1;
        bus_idle   <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timed_out("the break");
        end while (tx !== 1'b0);
        low = 0;
        n   = 0;
        while (tx === 1'b0) begin
            low++;
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timed_out("the end of the break");
        end
        check("break low clocks", low, 10 * (div + 1));
        check("break_done", 32'(break_done), 32'd1);
        @(posedge clk);
        send_break <= 1'b0;
        bus_idle   <= 1'b0;
    endtask

    // pull the line low under the first released one
    task automatic force_collision();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timed_out("the first start bit");
        end while (tx_en !== 1'b1);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timed_out("a released one");
        end while (!(tx_en === 1'b0 && tx === 1'b1));
        @(posedge clk);
        pull_low <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timed_out("cd");
        end while (cd !== 1'b1);
        @(posedge clk);
        pull_low <= 1'b0;
    endtask

    initial begin
        test_t       cur;
        logic [7:0]  b;
        logic [15:0] crc;
        int          t;
        int          k;
        int          n;
        int          pre_clk;
        int          err_before;
        int          cd_before;

        in_data       = '0;
        in_valid      = 1'b0;
        in_last       = 1'b0;
        div_ls        = div_t'(7);
        div_hs        = div_t'(7);
        tx_permit_len = len_t'(2);
        tx_pre_len    = 2'd0;
        arbitration   = 1'b0;
        abort         = 1'b0;
        send_break    = 1'b0;
        bus_idle      = 1'b0;
        pull_low      = 1'b0;
        lfsr_state    = 32'hebd5;
        errors        = 0;
        checks        = 0;
        cd_cnt        = 0;
        err_cnt       = 0;

        //           len ls  hs  arb pre col brk
        tests[0] = '{3,  7,  7,  0,  1,  0,  0};
        tests[1] = '{5,  11, 3,  1,  2,  0,  0};
        tests[2] = '{4,  9,  4,  1,  0,  1,  0};
        tests[3] = '{2,  7,  5,  0,  2,  0,  1};
        tests[4] = '{16, 5,  2,  0,  3,  0,  0};

        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timed_out("reset release");
        end while (reset_n !== 1'b1);
        check("tx after reset", 32'(tx), 32'd1);
        check("tx_en after reset", 32'(tx_en), 32'd0);
        check("in_ready after reset", 32'(in_ready), 32'd1);

        for (t = 0; t < N_TESTS; t++) begin
            cur        = tests[t];
            err_before = errors;
            cd_before  = cd_cnt;
            @(posedge clk);
            div_ls      <= div_t'(cur.div_ls);
            div_hs      <= div_t'(cur.div_hs);
            arbitration <= (cur.arb != 0);
            tx_pre_len  <= 2'(cur.pre);
            bus_idle    <= 1'b0;

            if (cur.brk != 0)
                send_break_char(cur.div_ls);

            frame_q.delete();
            crc = 16'hFFFF;
            for (k = 0; k < cur.len; k++) begin
                next_rand_byte(b);
                frame_q.push_back(b);
                crc = crc_add_byte(crc, b);
            end
            frame_q.push_back(crc[7:0]);    // low byte goes first
            frame_q.push_back(crc[15:8]);

            for (k = 0; k < cur.len; k++)
                push_byte(frame_q[k], k == cur.len - 1);
            @(posedge clk);
            in_valid <= 1'b0;
            in_last  <= 1'b0;
            @(negedge clk);
            check("in_ready while sending", 32'(in_ready), 32'd0);

            // nothing may start while the bus is busy
            watch_quiet_line(8 * (cur.div_ls + 1));
            @(posedge clk);
            bus_idle <= 1'b1;

            for (k = 0; k < cur.n_col; k++)
                force_collision();

            for (k = 0; k < cur.len + 2; k++) begin
                // preamble only ahead of the first byte and never under arbitration
                pre_clk = (k == 0 && cur.arb == 0) ? cur.pre * (cur.div_ls + 1) : 0;
                receive_char(k == 0 ? cur.div_ls : cur.div_hs, cur.arb != 0 && k == 0,
                             frame_q[k], k, pre_clk);
            end

            n = 0;
            do begin
                @(negedge clk);
                n++;
                if (n > WAIT_LIMIT)
                    timed_out("frame_done");
            end while (frame_done !== 1'b1);
            check("in_ready after frame_done", 32'(in_ready), 32'd1);
            check("cd pulses", cd_cnt - cd_before, cur.n_col);
            check("err pulses", err_cnt, 0);

            $display("test %0d: %0d payload bytes, %0d mismatches", t, cur.len,
                     errors - err_before);
        end

        $display("%0d tests run, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
// **************************************************
// free-running clock, reset_n held low at start
// reset_n rises on a clock edge
// **************************************************
module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule
